/* verilog/qspi_pkg.sv */
// shared widths and encodings; phase bit counts above DATA_W are not supported, lanes are single-bit only
package qspi_pkg;

    // bus and datapath widths
    localparam int BUS_AW = 8;
    localparam int DATA_W = 32;
    localparam int CNT_W  = 6;
    localparam int CMD_W  = 8;

    // CTRL launch bits
    localparam int CTRL_READ_BIT  = 0;
    localparam int CTRL_WRITE_BIT = 1;
    localparam int CTRL_DUMMY_BIT = 2;

    // STATUS bits
    localparam int STATUS_BUSY_BIT = 0;

    // register offsets on the bus
    typedef enum logic [BUS_AW-1:0] {
        CSR_CYCLE  = 8'd0,
        CSR_WDATA  = 8'd4,
        CSR_RDATA  = 8'd8,
        CSR_ADDR   = 8'd12,
        CSR_CMD    = 8'd16,
        CSR_CTRL   = 8'd20,
        CSR_STATUS = 8'd24
    } csr_addr_e;

    typedef enum logic [2:0] {IDLE, CMD, ADDR, DUMMY, DATA} seq_state_e;

    // packed so that cmd_bits lands on bits 5:0 of the cycle register
    typedef struct packed {
        logic [CNT_W-1:0] dummy_bits;
        logic [CNT_W-1:0] rdata_bits;
        logic [CNT_W-1:0] wdata_bits;
        logic [CNT_W-1:0] addr_bits;
        logic [CNT_W-1:0] cmd_bits;
    } cycle_cfg_t;

    typedef struct packed {
        cycle_cfg_t        cfg;
        logic [CMD_W-1:0]  cmd;
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              is_read;
        logic              use_dummy;
    } xfer_req_t;

    typedef struct packed {
        logic              load;
        logic [DATA_W-1:0] load_word;
        logic [CNT_W-1:0]  load_bits;
        logic              shift;
        logic              sample;
    } shift_ctl_t;

endpackage

/* verilog/qspi_csr.sv */
// register file; no bus back-pressure, CTRL reads as zero, a launch during busy is dropped
`timescale 1ns/100ps

module qspi_csr (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          we_i,
    input  logic                          re_i,
    input  logic [qspi_pkg::BUS_AW-1:0]   addr_i,
    input  logic [qspi_pkg::DATA_W-1:0]   wdata_i,
    output logic [qspi_pkg::DATA_W-1:0]   rdata_o,
    output logic                          start_o,
    output qspi_pkg::xfer_req_t           req_o,
    input  logic                          busy_i,
    input  logic                          done_i,
    input  logic [qspi_pkg::DATA_W-1:0]   rx_word_i
);

    qspi_pkg::cycle_cfg_t          cycle_q;
    logic [qspi_pkg::DATA_W-1:0]   wdata_q;
    logic [qspi_pkg::DATA_W-1:0]   addr_q;
    logic [qspi_pkg::DATA_W-1:0]   rdata_q;
    logic [qspi_pkg::CMD_W-1:0]    cmd_q;
    logic [qspi_pkg::DATA_W-1:0]   rd_mux;
    logic                          ctrl_wr;

    assign ctrl_wr = we_i && (addr_i == qspi_pkg::CSR_CTRL);

    // read bit wins when both launch bits are set
    assign start_o = ctrl_wr && !busy_i
                     && (wdata_i[qspi_pkg::CTRL_READ_BIT] || wdata_i[qspi_pkg::CTRL_WRITE_BIT]);

    always_comb begin
        req_o.cfg       = cycle_q;
        req_o.cmd       = cmd_q;
        req_o.addr      = addr_q;
        req_o.wdata     = wdata_q;
        req_o.is_read   = wdata_i[qspi_pkg::CTRL_READ_BIT];
        req_o.use_dummy = wdata_i[qspi_pkg::CTRL_DUMMY_BIT];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cycle_q <= '0;
            wdata_q <= '0;
            addr_q  <= '0;
            cmd_q   <= '0;
            rdata_q <= '0;
        end else begin
            if (we_i) begin
                case (addr_i)
                    qspi_pkg::CSR_CYCLE: cycle_q <= wdata_i[$bits(cycle_q)-1:0];
                    qspi_pkg::CSR_WDATA: wdata_q <= wdata_i;
                    qspi_pkg::CSR_ADDR:  addr_q  <= wdata_i;
                    qspi_pkg::CSR_CMD:   cmd_q   <= wdata_i[qspi_pkg::CMD_W-1:0];
                    default: ;
                endcase
            end
            // read word lands here when the sequencer finishes
            if (done_i) begin
                rdata_q <= rx_word_i;
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (addr_i)
            qspi_pkg::CSR_CYCLE:  rd_mux[$bits(cycle_q)-1:0] = cycle_q;
            qspi_pkg::CSR_WDATA:  rd_mux = wdata_q;
            qspi_pkg::CSR_RDATA:  rd_mux = rdata_q;
            qspi_pkg::CSR_ADDR:   rd_mux = addr_q;
            qspi_pkg::CSR_CMD:    rd_mux[qspi_pkg::CMD_W-1:0] = cmd_q;
            qspi_pkg::CSR_STATUS: rd_mux[qspi_pkg::STATUS_BUSY_BIT] = busy_i;
            default: ;
        endcase
    end

    // read data one cycle after re_i
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (re_i) begin
            rdata_o <= rd_mux;
        end
    end

    a_start_accepted: assert property (
        @(posedge clk_i) disable iff (!rst_ni) start_o |=> busy_i
    ) else $error("launch not taken up by the sequencer");

endmodule

/* verilog/qspi_sequencer.sv */
// phase sequencer; one serial bit spans two clk_i cycles (mode 0), zero-count phases are skipped
`timescale 1ns/100ps

module qspi_sequencer (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  start_i,
    input  qspi_pkg::xfer_req_t   req_i,
    output logic                  busy_o,
    output logic                  done_o,
    output qspi_pkg::shift_ctl_t  ctl_o,
    output logic                  sclk_o,
    output logic                  csb_o,
    output logic [3:0]            oeb_o
);

    qspi_pkg::seq_state_e          state_q;
    qspi_pkg::seq_state_e          nxt;
    qspi_pkg::xfer_req_t           req_q;
    qspi_pkg::xfer_req_t           cur_req;
    logic [qspi_pkg::CNT_W-1:0]    bit_cnt_q;
    logic                          half_q;
    logic                          tail_q;
    logic                          done_q;
    logic                          active;
    logic                          last_bit;
    logic                          enter;
    logic                          finish;
    logic                          drive;

    // fixed phase order before skipping
    function automatic qspi_pkg::seq_state_e following(qspi_pkg::seq_state_e s);
        case (s)
            qspi_pkg::IDLE:  return qspi_pkg::CMD;
            qspi_pkg::CMD:   return qspi_pkg::ADDR;
            qspi_pkg::ADDR:  return qspi_pkg::DUMMY;
            qspi_pkg::DUMMY: return qspi_pkg::DATA;
            default:         return qspi_pkg::IDLE;
        endcase
    endfunction

    function automatic logic [qspi_pkg::CNT_W-1:0] phase_bits(qspi_pkg::seq_state_e s,
                                                              qspi_pkg::xfer_req_t r);
        case (s)
            qspi_pkg::CMD:   return r.cfg.cmd_bits;
            qspi_pkg::ADDR:  return r.cfg.addr_bits;
            // writes never see a dummy phase
            qspi_pkg::DUMMY: return (r.is_read && r.use_dummy) ? r.cfg.dummy_bits : '0;
            qspi_pkg::DATA:  return r.is_read ? r.cfg.rdata_bits : r.cfg.wdata_bits;
            default:         return '0;
        endcase
    endfunction

    function automatic logic [qspi_pkg::DATA_W-1:0] phase_word(qspi_pkg::seq_state_e s,
                                                               qspi_pkg::xfer_req_t r);
        logic [qspi_pkg::DATA_W-1:0] word;
        word = '0;
        case (s)
            qspi_pkg::CMD:  word[qspi_pkg::CMD_W-1:0] = r.cmd;
            qspi_pkg::ADDR: word = r.addr;
            qspi_pkg::DATA: word = r.is_read ? '0 : r.wdata;
            default: ;
        endcase
        return word;
    endfunction

    function automatic qspi_pkg::seq_state_e next_phase(qspi_pkg::seq_state_e s,
                                                        qspi_pkg::xfer_req_t r);
        qspi_pkg::seq_state_e n;
        n = following(s);
        for (int i = 0; i < 4; i++) begin
            if (n != qspi_pkg::IDLE && phase_bits(n, r) == '0) begin
                n = following(n);
            end
        end
        return n;
    endfunction

    always_comb begin
        active   = (state_q != qspi_pkg::IDLE);
        // request comes straight from the bus while idle
        cur_req  = active ? req_q : req_i;
        last_bit = half_q && (bit_cnt_q == '0);
        enter    = active ? last_bit : start_i;
        nxt      = next_phase(state_q, cur_req);
        finish   = active && last_bit && (nxt == qspi_pkg::IDLE);
    end

    // load lands on the edge that opens the next phase
    always_comb begin
        ctl_o.load      = enter && (nxt != qspi_pkg::IDLE);
        ctl_o.load_word = phase_word(nxt, cur_req);
        ctl_o.load_bits = phase_bits(nxt, cur_req);
        ctl_o.shift     = active && half_q && !last_bit;
        ctl_o.sample    = (state_q == qspi_pkg::DATA) && req_q.is_read && !half_q;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= qspi_pkg::IDLE;
            half_q    <= 1'b0;
            bit_cnt_q <= '0;
            tail_q    <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            if (enter) begin
                state_q <= nxt;
            end
            half_q <= active ? ~half_q : 1'b0;
            if (ctl_o.load) begin
                bit_cnt_q <= ctl_o.load_bits - 1'b1;
            end else if (active && half_q) begin
                bit_cnt_q <= bit_cnt_q - 1'b1;
            end
            // busy lingers one cycle past chip select
            tail_q <= finish;
            done_q <= finish && req_q.is_read;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!active && start_i) begin
            req_q <= req_i;
        end
    end

    always_comb begin
        drive = (state_q == qspi_pkg::CMD) || (state_q == qspi_pkg::ADDR)
                || ((state_q == qspi_pkg::DATA) && !req_q.is_read);
        oeb_o = drive ? 4'b0000 : 4'b1111;
    end

    assign busy_o = active || tail_q;
    assign done_o = done_q;
    assign csb_o  = !active;
    assign sclk_o = active && half_q;

    a_csb_rise_on_last_bit: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $rose(csb_o) |-> $past(last_bit)
    ) else $error("chip select rose before the last bit completed");

    a_sclk_low_idle: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !active |-> !half_q
    ) else $error("serial clock phase left high in IDLE");

endmodule

/* verilog/qspi_shifter.sv */
// single-lane shifter, MSB first; load fields wider than DATA_W bits are not supported
`timescale 1ns/100ps

module qspi_shifter (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  qspi_pkg::shift_ctl_t          ctl_i,
    input  logic                          rx_bit_i,
    output logic                          tx_bit_o,
    output logic [qspi_pkg::DATA_W-1:0]   rx_word_o
);

    logic [qspi_pkg::DATA_W-1:0] tx_q;
    logic [qspi_pkg::DATA_W-1:0] rx_q;
    logic [qspi_pkg::DATA_W-1:0] tx_aligned;

    // move the right-aligned field up so its top bit leaves first
    always_comb begin
        tx_aligned = ctl_i.load_word << (qspi_pkg::DATA_W - int'(ctl_i.load_bits));
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tx_q <= '0;
        end else if (ctl_i.load) begin
            tx_q <= tx_aligned;
        end else if (ctl_i.shift) begin
            tx_q <= {tx_q[qspi_pkg::DATA_W-2:0], 1'b0};
        end
    end

    // receive side, cleared per phase so N sampled bits end right-aligned
    always_ff @(posedge clk_i) begin
        if (ctl_i.load) begin
            rx_q <= '0;
        end else if (ctl_i.sample) begin
            rx_q <= {rx_q[qspi_pkg::DATA_W-2:0], rx_bit_i};
        end
    end

    assign tx_bit_o  = tx_q[qspi_pkg::DATA_W-1];
    assign rx_word_o = rx_q;

endmodule

/* verilog/qspi_core.sv */
// serial flash controller top; single-lane only, lanes 1 to 3 of qspi_o are held at zero
`timescale 1ns/100ps

module qspi_core (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // register bus
    input  logic                          we_i,
    input  logic                          re_i,
    input  logic [qspi_pkg::BUS_AW-1:0]   addr_i,
    input  logic [qspi_pkg::DATA_W-1:0]   wdata_i,
    output logic [qspi_pkg::DATA_W-1:0]   rdata_o,
    // flash pins
    output logic                          qsclk_o,
    output logic                          qcsb_o,
    input  logic [3:0]                    qspi_i,
    output logic [3:0]                    qspi_o,
    output logic [3:0]                    qspi_oeb
);

    qspi_pkg::xfer_req_t           req;
    qspi_pkg::shift_ctl_t          ctl;
    logic                          start;
    logic                          busy;
    logic                          done;
    logic                          tx_bit;
    logic [qspi_pkg::DATA_W-1:0]   rx_word;

    qspi_csr u_csr (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .we_i      (we_i),
        .re_i      (re_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .rdata_o   (rdata_o),
        .start_o   (start),
        .req_o     (req),
        .busy_i    (busy),
        .done_i    (done),
        .rx_word_i (rx_word)
    );

    qspi_sequencer u_sequencer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .start_i (start),
        .req_i   (req),
        .busy_o  (busy),
        .done_o  (done),
        .ctl_o   (ctl),
        .sclk_o  (qsclk_o),
        .csb_o   (qcsb_o),
        .oeb_o   (qspi_oeb)
    );

    // flash output arrives on lane 1
    qspi_shifter u_shifter (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .ctl_i     (ctl),
        .rx_bit_i  (qspi_i[1]),
        .tx_bit_o  (tx_bit),
        .rx_word_o (rx_word)
    );

    assign qspi_o = {3'b000, tx_bit};

endmodule

/* tb/flash_model.sv */
// behavioral serial flash, mode 0 on one lane; 256 words, other addresses read zero and drop writes
`timescale 1ns/100ps

module flash_model #(
    parameter logic [7:0] READ_OP    = 8'h03,
    parameter logic [7:0] PROGRAM_OP = 8'h02
) (
    input  logic        sclk_i,
    input  logic        csb_i,
    input  logic        mosi_i,
    output logic        miso_o,
    input  logic [5:0]  addr_bits_i,
    input  logic [5:0]  dummy_bits_i,
    input  logic [5:0]  data_bits_i,
    input  logic [31:0] preset_i [0:255]
);

    localparam int DEPTH = 256;

    logic [31:0]      written [0:DEPTH-1];
    logic [DEPTH-1:0] programmed;
    logic [7:0]       cmd;
    logic [31:0]      addr;
    logic [31:0]      wword;
    logic [31:0]      rword;
    int               bit_idx;

    initial begin : serial_port
        logic prev_sclk;
        logic prev_csb;
        int   first;
        int   last;
        miso_o     = 1'b0;
        cmd        = '0;
        addr       = '0;
        wword      = '0;
        rword      = '0;
        bit_idx    = 0;
        programmed = '0;
        prev_sclk  = 1'b0;
        prev_csb   = 1'b1;
        forever begin
            @(sclk_i or csb_i);
            first = 8 + int'(addr_bits_i) + int'(dummy_bits_i);
            last  = first + int'(data_bits_i);
            if (csb_i === 1'b0 && prev_csb !== 1'b0) begin
                // chip select fell, new command follows
                bit_idx = 0;
                cmd     = '0;
                addr    = '0;
                wword   = '0;
            end else if (csb_i === 1'b1 && prev_csb === 1'b0) begin
                miso_o = 1'b0;
                // program only a complete frame
                if (cmd == PROGRAM_OP && bit_idx == 8 + int'(addr_bits_i) + int'(data_bits_i)
                    && addr < DEPTH) begin
                    written[addr[7:0]]    = wword;
                    programmed[addr[7:0]] = 1'b1;
                end
            end else if (csb_i === 1'b0 && sclk_i === 1'b1 && prev_sclk !== 1'b1) begin
                if (bit_idx < 8) begin
                    cmd = {cmd[6:0], mosi_i};
                end else if (bit_idx < 8 + int'(addr_bits_i)) begin
                    addr = {addr[30:0], mosi_i};
                end else begin
                    wword = {wword[30:0], mosi_i};
                end
                bit_idx++;
            end else if (csb_i === 1'b0 && sclk_i === 1'b0 && prev_sclk === 1'b1
                         && cmd == READ_OP) begin
                // word fetched once dummy bits are over
                if (bit_idx == first) begin
                    if (addr >= DEPTH) begin
                        rword = '0;
                    end else if (programmed[addr[7:0]]) begin
                        rword = written[addr[7:0]];
                    end else begin
                        rword = preset_i[addr[7:0]];
                    end
                end
                if (bit_idx >= first && bit_idx < last) begin
                    miso_o = rword[last - 1 - bit_idx];
                end else begin
                    miso_o = 1'b0;
                end
            end
            prev_sclk = sclk_i;
            prev_csb  = csb_i;
        end
    end

endmodule

/* tb/tb_qspi_core.sv */
// testbench for qspi_core; flash addresses stay below 256, command phase is always 8 bits
`timescale 1ns/100ps

module tb_qspi_core;

    localparam logic [7:0] READ_OP    = 8'h03;
    localparam logic [7:0] PROGRAM_OP = 8'h02;
    localparam int NUM_ROWS       = 12;
    localparam int TIMEOUT_CYCLES = 2000 * NUM_ROWS;

    typedef enum logic [1:0] {REG_ACCESS, FLASH_READ, FLASH_WRITE} kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [7:0]  reg_off;
        logic [7:0]  cmd;
        logic [5:0]  addr_bits;
        logic [5:0]  dummy_bits;
        logic [5:0]  data_bits;
        logic        use_dummy;
        logic        relaunch;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
    } row_t;

    logic        clk_i;
    logic        rst_ni;
    logic        we_i;
    logic        re_i;
    logic [7:0]  addr_i;
    logic [31:0] wdata_i;
    logic [31:0] rdata_o;
    logic        qsclk_o;
    logic        qcsb_o;
    logic [3:0]  qspi_i;
    logic [3:0]  qspi_o;
    logic [3:0]  qspi_oeb;
    logic        flash_miso;
    logic [5:0]  flash_addr_bits;
    logic [5:0]  flash_dummy_bits;
    logic [5:0]  flash_data_bits;
    logic [31:0] image [0:255];
    row_t        rows [0:NUM_ROWS-1];
    int          cycle_count = 0;
    int          cs_low_total = 0;
    int          cs_start = 0;
    int          drive_cycles = 0;

    assign qspi_i = {2'b00, flash_miso, 1'b0};

    qspi_core u_qspi_core (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .we_i     (we_i),
        .re_i     (re_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .rdata_o  (rdata_o),
        .qsclk_o  (qsclk_o),
        .qcsb_o   (qcsb_o),
        .qspi_i   (qspi_i),
        .qspi_o   (qspi_o),
        .qspi_oeb (qspi_oeb)
    );

    flash_model #(.READ_OP(READ_OP), .PROGRAM_OP(PROGRAM_OP)) u_flash (
        .sclk_i       (qsclk_o),
        .csb_i        (qcsb_o),
        .mosi_i       (qspi_o[0]),
        .miso_o       (flash_miso),
        .addr_bits_i  (flash_addr_bits),
        .dummy_bits_i (flash_dummy_bits),
        .data_bits_i  (flash_data_bits),
        .preset_i     (image)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the table did not finish within the cycle limit");
        end
    end

    // chip select and output enables sampled mid-cycle
    always @(negedge clk_i) begin
        if (qcsb_o === 1'b0) begin
            // enables held through command, address and write data only
            check_value("qspi_oeb", {28'd0, qspi_oeb},
                        (cs_low_total - cs_start < drive_cycles) ? 32'h0 : 32'hF);
            cs_low_total++;
        end else begin
            check_value("qspi_oeb", {28'd0, qspi_oeb}, 32'hF);
        end
        check_value("qspi_o[3:1]", {29'd0, qspi_o[3:1]}, 32'h0);
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] low_bits(logic [31:0] w, int n);
        if (n >= 32) begin
            return w;
        end
        return w & ((32'd1 << n) - 32'd1);
    endfunction

    function automatic row_t reg_row(logic [7:0] off, logic [31:0] data, logic [31:0] expected);
        row_t r;
        r          = '0;
        r.kind     = REG_ACCESS;
        r.reg_off  = off;
        r.data     = data;
        r.expected = expected;
        return r;
    endfunction

    function automatic row_t flash_row(kind_e kind, logic [5:0] ab, logic [5:0] db,
                                       logic use_dummy, logic relaunch, logic [31:0] addr,
                                       logic [31:0] data, logic [31:0] expected);
        row_t r;
        r            = '0;
        r.kind       = kind;
        r.cmd        = (kind == FLASH_READ) ? READ_OP : PROGRAM_OP;
        r.addr_bits  = ab;
        r.dummy_bits = 6'd8;
        r.data_bits  = db;
        r.use_dummy  = use_dummy;
        r.relaunch   = relaunch;
        r.addr       = addr;
        r.data       = data;
        r.expected   = expected;
        return r;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
        $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, expected);
        $display("ERRORS FOUND");
        $fatal(1, "value check failed");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        assert (got === expected) else report_mismatch(name, got, expected);
    endtask

    task automatic bus_write(input logic [7:0] off, input logic [31:0] data);
        @(posedge clk_i);
        we_i    <= 1'b1;
        addr_i  <= off;
        wdata_i <= data;
        @(posedge clk_i);
        we_i    <= 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] off, output logic [31:0] data);
        @(posedge clk_i);
        re_i   <= 1'b1;
        addr_i <= off;
        @(posedge clk_i);
        re_i   <= 1'b0;
        @(negedge clk_i);
        data = rdata_o;
    endtask

    task automatic run_row(row_t r);
        logic [31:0] got;
        logic [31:0] status;
        int          expected_cycles;
        if (r.kind == REG_ACCESS) begin
            bus_write(r.reg_off, r.data);
            bus_read(r.reg_off, got);
            check_value("rdata_o", got, r.expected);
        end else begin
            bus_write(qspi_pkg::CSR_CYCLE,
                      {2'b00, r.dummy_bits, r.data_bits, r.data_bits, r.addr_bits, 6'd8});
            bus_write(qspi_pkg::CSR_CMD, {24'd0, r.cmd});
            bus_write(qspi_pkg::CSR_ADDR, r.addr);
            bus_write(qspi_pkg::CSR_WDATA, r.data);
            flash_addr_bits  = r.addr_bits;
            flash_dummy_bits = (r.kind == FLASH_READ && r.use_dummy) ? r.dummy_bits : 6'd0;
            flash_data_bits  = r.data_bits;
            expected_cycles  = 2 * (8 + int'(r.addr_bits) + int'(flash_dummy_bits)
                                    + int'(r.data_bits));
            drive_cycles     = (r.kind == FLASH_READ) ? 2 * (8 + int'(r.addr_bits))
                                                      : expected_cycles;
            cs_start = cs_low_total;
            if (r.kind == FLASH_READ) begin
                bus_write(qspi_pkg::CSR_CTRL, {29'd0, r.use_dummy, 2'b01});
            end else begin
                bus_write(qspi_pkg::CSR_CTRL, 32'h0000_0002);
            end
            // lands while the first transfer is still running
            if (r.relaunch) begin
                bus_write(qspi_pkg::CSR_CTRL, 32'h0000_0002);
            end
            do begin
                bus_read(qspi_pkg::CSR_STATUS, status);
            end while (status[0]);
            check_value("qcsb_o low cycles", cs_low_total - cs_start, expected_cycles);
            if (r.kind == FLASH_READ) begin
                bus_read(qspi_pkg::CSR_RDATA, got);
                check_value("rdata_o", got, r.expected);
            end
        end
    endtask

    initial begin : main
        logic [31:0] state;
        rst_ni           = 1'b0;
        we_i             = 1'b0;
        re_i             = 1'b0;
        addr_i           = '0;
        wdata_i          = '0;
        flash_addr_bits  = '0;
        flash_dummy_bits = '0;
        flash_data_bits  = '0;
        state = 32'd22;
        for (int i = 0; i < 256; i++) begin
            state    = xorshift(state);
            image[i] = state;
        end
        rows[0]  = reg_row(qspi_pkg::CSR_CYCLE, 32'h1234_5678, 32'h1234_5678);
        rows[1]  = reg_row(qspi_pkg::CSR_WDATA, 32'hDEAD_BEEF, 32'hDEAD_BEEF);
        rows[2]  = reg_row(qspi_pkg::CSR_ADDR, 32'h00A5_5A5A, 32'h00A5_5A5A);
        rows[3]  = reg_row(qspi_pkg::CSR_CMD, 32'h0000_00C3, 32'h0000_00C3);
        rows[4]  = reg_row(8'h40, 32'hFFFF_FFFF, 32'h0);
        rows[5]  = reg_row(qspi_pkg::CSR_RDATA, 32'h55AA_55AA, 32'h0);
        rows[6]  = flash_row(FLASH_READ, 6'd24, 6'd32, 1'b0, 1'b0, 32'h10, 32'h0, image[16]);
        rows[7]  = flash_row(FLASH_WRITE, 6'd24, 6'd32, 1'b0, 1'b0, 32'h20, 32'hCAFE_F00D, 32'h0);
        rows[8]  = flash_row(FLASH_READ, 6'd24, 6'd32, 1'b0, 1'b0, 32'h20, 32'h0, 32'hCAFE_F00D);
        rows[9]  = flash_row(FLASH_READ, 6'd24, 6'd32, 1'b1, 1'b0, 32'h33, 32'h0, image[51]);
        rows[10] = flash_row(FLASH_READ, 6'd24, 6'd32, 1'b0, 1'b1, 32'h41, 32'h0, image[65]);
        rows[11] = flash_row(FLASH_READ, 6'd16, 6'd16, 1'b0, 1'b0, 32'h07, 32'h0,
                             low_bits(image[7], 16));
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* sim.f */
verilog/qspi_pkg.sv
verilog/qspi_csr.sv
verilog/qspi_sequencer.sv
verilog/qspi_shifter.sv
verilog/qspi_core.sv
tb/flash_model.sv
tb/tb_qspi_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_qspi_core
FILELIST  := sim.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -j 0
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# $fatal in the testbench gives a non-zero exit status
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
